// ==== sim.f ====
hdl/axi_pkg.sv
hdl/mem_msg_pkg.sv
hdl/mem_fwd_if.sv
hdl/mem_rev_if.sv
hdl/axi_subordinate.sv
hdl/mem_fwd_router.sv
hdl/mem_bank.sv
hdl/mem_rev_merger.sv
hdl/axi_mem_top.sv
testbench/tb_axi_mem_top.sv

// ==== testbench/tb_axi_mem_top.sv ====
`timescale 1ns/10ps

module tb_axi_mem_top
  import axi_pkg::*;
  ();

  localparam int ID_W       = 4;
  localparam int NUM_BANKS  = 4;
  localparam int BANK_WORDS = 16;
  localparam int FIFO_DEPTH = 2;
  localparam int MEM_WORDS  = NUM_BANKS * BANK_WORDS;
  localparam int RAND_TXNS  = 200;
  localparam int BP_TXNS    = 60;
  localparam int PAR_ROUNDS = 8;
  localparam int NUM_TXNS   = 2 * MEM_WORDS + 8 + RAND_TXNS + 9 + BP_TXNS + 2 * PAR_ROUNDS;
  localparam int TIMEOUT_CYCLES = NUM_TXNS * 50 + 100;  // margin for reset and test gaps

  typedef struct packed {
    logic [ID_W-1:0] id;
    axi_resp_t       resp;
    axi_data_t       data;
  } resp_exp_t;

  logic            clk_i, arst_n_i;
  logic [ID_W-1:0] awid_i, arid_i, bid_o, rid_o;
  axi_addr_t       awaddr_i, araddr_i;
  axi_len_t        awlen_i, arlen_i;
  logic            awvalid_i, awready_o, wlast_i, wvalid_i, wready_o;
  axi_data_t       wdata_i, rdata_o;
  axi_strb_t       wstrb_i;
  axi_resp_t       bresp_o, rresp_o;
  logic            bvalid_o, bready_i, arvalid_i, arready_o;
  logic            rlast_o, rvalid_o, rready_i;

  axi_data_t       shadow [MEM_WORDS];  // whole memory as seen from AXI
  resp_exp_t       exp_b_q [$];
  resp_exp_t       exp_r_q [$];
  logic [1:0]      bp_pat [256];        // bit 0 bready, bit 1 rready
  logic            bp_en;
  int unsigned     cycle_cnt;
  int              err_cnt, check_cnt, test_cnt, test_err_base;
  logic            b_hold_q, r_hold_q;
  resp_exp_t       b_held, r_held;

  axi_mem_top #(
    .ID_WIDTH(ID_W),
    .NUM_BANKS(NUM_BANKS),
    .BANK_WORDS(BANK_WORDS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) uut (.*);

  always #50 clk_i = ~clk_i;

  // ------------------------------
  // reference and checking
  // ------------------------------
  function automatic axi_data_t fill_word(input int unsigned w);
    return {w ^ 32'hA5A5_0F0F, w * 32'h9E37_79B9};  // every address bit matters
  endfunction

  function automatic void predict_response(input logic is_wr, input axi_addr_t addr,
                                           input axi_len_t len, input logic last,
                                           input axi_data_t data, input axi_strb_t strb,
                                           output axi_resp_t resp, output axi_data_t rdata);
    logic [28:0] word;
    word  = addr[31:3];
    rdata = '0;
    if (len != 0 || (is_wr && !last)) begin
      resp = RESP_SLVERR;
    end else if (word >= MEM_WORDS) begin
      resp = RESP_DECERR;
    end else begin
      resp = RESP_OKAY;
      if (is_wr) begin
        for (int i = 0; i < 8; i++) begin
          if (strb[i]) shadow[word][8*i +: 8] = data[8*i +: 8];
        end
      end else begin
        rdata = shadow[word];
      end
    end
  endfunction

  task automatic compare_value(input string name, input logic [63:0] exp,
                               input logic [63:0] act);
    check_cnt++;
    if (act !== exp) begin
      $display("MISMATCH %s: expected 0x%0h, got 0x%0h at %0t", name, exp, act, $time);
      err_cnt++;
    end
  endtask

  // watches every B and R handshake, and held responses
  always @(posedge clk_i) begin
    if (arst_n_i) begin
      if (b_hold_q) begin
        if (!bvalid_o) begin
          $display("B response withdrawn while bready was low at %0t", $time);
          err_cnt++;
        end else begin
          compare_value("bid_o (held)", b_held.id, bid_o);
          compare_value("bresp_o (held)", b_held.resp, bresp_o);
        end
      end
      if (r_hold_q) begin
        if (!rvalid_o) begin
          $display("R response withdrawn while rready was low at %0t", $time);
          err_cnt++;
        end else begin
          compare_value("rid_o (held)", r_held.id, rid_o);
          compare_value("rdata_o (held)", r_held.data, rdata_o);
          compare_value("rresp_o (held)", r_held.resp, rresp_o);
        end
      end
      if (bvalid_o && bready_i) begin
        if (exp_b_q.size() == 0) begin
          $display("B response arrived with no write outstanding at %0t", $time);
          err_cnt++;
        end else begin
          b_held = exp_b_q.pop_front();
          compare_value("bid_o", b_held.id, bid_o);
          compare_value("bresp_o", b_held.resp, bresp_o);
        end
      end
      if (rvalid_o && rready_i) begin
        if (exp_r_q.size() == 0) begin
          $display("R response arrived with no read outstanding at %0t", $time);
          err_cnt++;
        end else begin
          r_held = exp_r_q.pop_front();
          compare_value("rid_o", r_held.id, rid_o);
          compare_value("rdata_o", r_held.data, rdata_o);
          compare_value("rresp_o", r_held.resp, rresp_o);
          compare_value("rlast_o", 1'b1, rlast_o);
        end
      end
      b_hold_q = bvalid_o && !bready_i;
      r_hold_q = rvalid_o && !rready_i;
      if (b_hold_q) b_held = '{id: bid_o, resp: bresp_o, data: '0};
      if (r_hold_q) r_held = '{id: rid_o, resp: rresp_o, data: rdata_o};
    end
  end

  // response back-pressure
  always @(posedge clk_i) begin
    #1;
    cycle_cnt++;
    bready_i = bp_en ? bp_pat[cycle_cnt % 256][0] : 1'b1;
    rready_i = bp_en ? bp_pat[cycle_cnt % 256][1] : 1'b1;
  end

  // ------------------------------
  // transaction tasks
  // ------------------------------
  task automatic axi_write(input logic [ID_W-1:0] id, input axi_addr_t addr,
                           input axi_len_t len, input axi_data_t data,
                           input axi_strb_t strb, input logic last);
    resp_exp_t e;
    logic      aw_done, w_done;
    e.id = id;
    predict_response(1'b1, addr, len, last, data, strb, e.resp, e.data);
    e.data = '0;
    exp_b_q.push_back(e);
    awid_i    = id;
    awaddr_i  = addr;
    awlen_i   = len;
    awvalid_i = 1'b1;
    wdata_i   = data;
    wstrb_i   = strb;
    wlast_i   = last;
    wvalid_i  = 1'b1;
    aw_done   = 1'b0;
    w_done    = 1'b0;
    while (!(aw_done && w_done)) begin
      @(posedge clk_i);
      if (awvalid_i && awready_o) aw_done = 1'b1;
      if (wvalid_i && wready_o) w_done = 1'b1;
      #1;
      if (aw_done) awvalid_i = 1'b0;
      if (w_done) wvalid_i = 1'b0;
    end
    do @(posedge clk_i); while (!(bvalid_o && bready_i));
    #1;
  endtask

  task automatic axi_read(input logic [ID_W-1:0] id, input axi_addr_t addr,
                          input axi_len_t len);
    resp_exp_t e;
    e.id = id;
    predict_response(1'b0, addr, len, 1'b1, '0, '0, e.resp, e.data);
    exp_r_q.push_back(e);
    arid_i    = id;
    araddr_i  = addr;
    arlen_i   = len;
    arvalid_i = 1'b1;
    do @(posedge clk_i); while (!(arvalid_i && arready_o));
    #1;
    arvalid_i = 1'b0;
    do @(posedge clk_i); while (!(rvalid_o && rready_i));
    #1;
  endtask

  task automatic random_txn();
    axi_addr_t addr;
    addr = axi_addr_t'($urandom_range(0, MEM_WORDS - 1)) << 3;
    if ($urandom_range(0, 1))
      axi_write(ID_W'($urandom), addr, 8'd0, {$urandom, $urandom}, 8'($urandom), 1'b1);
    else
      axi_read(ID_W'($urandom), addr, 8'd0);
  endtask

  task automatic end_test(input string name);
    repeat (2) @(posedge clk_i);
    #1;
    if (exp_b_q.size() != 0 || exp_r_q.size() != 0) begin
      $display("%s: a response never arrived", name);
      err_cnt++;
    end
    test_cnt++;
    $display("test %0d (%s) done, %0d errors", test_cnt, name, err_cnt - test_err_base);
    test_err_base = err_cnt;
  endtask

  // ------------------------------
  // watchdog
  // ------------------------------
  initial begin
    repeat (TIMEOUT_CYCLES) @(posedge clk_i);
    $display("timeout: run did not end within %0d cycles, a transaction is stuck",
             TIMEOUT_CYCLES);
    $display("Finished with errors");
    $finish;
  end

  // ------------------------------
  // test sequence
  // ------------------------------
  initial begin
    int unsigned w1, w2;
    void'($urandom(32'he6811209));
    for (int i = 0; i < 256; i++) bp_pat[i] = 2'($urandom);
    clk_i = 1'b0;
    arst_n_i = 1'b0;
    {awid_i, awaddr_i, awlen_i, awvalid_i} = '0;
    {wdata_i, wstrb_i, wlast_i, wvalid_i} = '0;
    {arid_i, araddr_i, arlen_i, arvalid_i} = '0;
    bready_i = 1'b0;
    rready_i = 1'b0;
    bp_en = 1'b0;
    cycle_cnt = 0;
    {err_cnt, check_cnt, test_cnt, test_err_base} = '0;
    b_hold_q = 1'b0;
    r_hold_q = 1'b0;
    repeat (3) @(posedge clk_i);
    #1 arst_n_i = 1'b1;

    compare_value("bvalid_o", 1'b0, bvalid_o);
    compare_value("rvalid_o", 1'b0, rvalid_o);
    compare_value("awready_o", 1'b1, awready_o);
    compare_value("wready_o", 1'b1, wready_o);
    compare_value("arready_o", 1'b1, arready_o);
    for (int w = 0; w < MEM_WORDS; w++)  // every bank gets every word
      axi_write(ID_W'(w), axi_addr_t'(w) << 3, 8'd0, fill_word(w), 8'hFF, 1'b1);
    for (int w = 0; w < MEM_WORDS; w++)
      axi_read(ID_W'(w + 1), axi_addr_t'(w) << 3, 8'd0);
    end_test("fill and read back");

    axi_write(4'h1, 32'h30, 8'd0, 64'h1111_2222_3333_4444, 8'h0F, 1'b1);
    axi_read(4'h2, 32'h30, 8'd0);
    axi_write(4'h3, 32'h30, 8'd0, 64'h5555_6666_7777_8888, 8'hF0, 1'b1);
    axi_read(4'h4, 32'h30, 8'd0);
    axi_write(4'h5, 32'h48, 8'd0, 64'h99AA_BBCC_DDEE_FF00, 8'hA5, 1'b1);
    axi_read(4'h6, 32'h48, 8'd0);
    axi_write(4'h7, 32'h50, 8'd0, 64'hFFFF_FFFF_FFFF_FFFF, 8'h00, 1'b1);
    axi_read(4'h8, 32'h50, 8'd0);
    end_test("partial strobes");

    repeat (RAND_TXNS) random_txn();
    end_test("random traffic");

    axi_write(4'h1, 32'h18, 8'd1, 64'hDEAD_BEEF_DEAD_BEEF, 8'hFF, 1'b1);
    axi_write(4'h2, 32'h20, 8'd0, 64'hDEAD_BEEF_DEAD_BEEF, 8'hFF, 1'b0);
    axi_write(4'h3, axi_addr_t'(MEM_WORDS) << 3, 8'd0, 64'hDEAD_BEEF, 8'hFF, 1'b1);
    axi_read(4'h4, 32'h28, 8'd3);
    axi_read(4'h5, axi_addr_t'(MEM_WORDS) << 3, 8'd0);
    axi_read(4'h6, 32'hFFFF_FFF8, 8'd0);
    axi_read(4'h7, 32'h18, 8'd0);
    axi_read(4'h8, 32'h20, 8'd0);
    axi_read(4'h9, 32'h00, 8'd0);  // alias of the first word past the end
    end_test("error responses");

    bp_en = 1'b1;
    repeat (BP_TXNS) random_txn();
    bp_en = 1'b0;
    end_test("back-pressure");

    for (int i = 0; i < PAR_ROUNDS; i++) begin
      w1 = $urandom_range(0, MEM_WORDS - 1);
      w2 = (w1 + 1 + $urandom_range(0, MEM_WORDS - 2)) % MEM_WORDS;  // never w1
      fork
        axi_write(ID_W'(i), axi_addr_t'(w1) << 3, 8'd0, {$urandom, $urandom}, 8'hFF, 1'b1);
        axi_read(ID_W'(i + 8), axi_addr_t'(w2) << 3, 8'd0);
      join
    end
    end_test("parallel write and read");

    $display("%0d tests, %0d checks, %0d errors", test_cnt, check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("Finished with no errors");
    else
      $display("Finished with errors");
    $finish;
  end

endmodule

// ==== hdl/axi_mem_top.sv ====
`timescale 1ns/10ps

module axi_mem_top
  import axi_pkg::*;
  #(parameter int ID_WIDTH   = 4,
    parameter int NUM_BANKS  = 4,
    parameter int BANK_WORDS = 16,
    parameter int FIFO_DEPTH = 2)
  (input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic [ID_WIDTH-1:0] awid_i,
   input  axi_addr_t           awaddr_i,
   input  axi_len_t            awlen_i,
   input  logic                awvalid_i,
   output logic                awready_o,
   input  axi_data_t           wdata_i,
   input  axi_strb_t           wstrb_i,
   input  logic                wlast_i,
   input  logic                wvalid_i,
   output logic                wready_o,
   output logic [ID_WIDTH-1:0] bid_o,
   output axi_resp_t           bresp_o,
   output logic                bvalid_o,
   input  logic                bready_i,
   input  logic [ID_WIDTH-1:0] arid_i,
   input  axi_addr_t           araddr_i,
   input  axi_len_t            arlen_i,
   input  logic                arvalid_i,
   output logic                arready_o,
   output logic [ID_WIDTH-1:0] rid_o,
   output axi_data_t           rdata_o,
   output axi_resp_t           rresp_o,
   output logic                rlast_o,
   output logic                rvalid_o,
   input  logic                rready_i);

  mem_fwd_if fwd ();                   // front end to router
  mem_fwd_if bank_fwd [NUM_BANKS] ();
  mem_rev_if bank_rev [NUM_BANKS] ();
  mem_rev_if rev ();                   // merger to front end

  axi_subordinate #(
    .ID_WIDTH(ID_WIDTH),
    .BANK_WORDS(BANK_WORDS),
    .NUM_BANKS(NUM_BANKS)
  ) u_sub (.*);

  mem_fwd_router #(
    .NUM_BANKS(NUM_BANKS),
    .FIFO_DEPTH(FIFO_DEPTH)
  ) u_router (
    .clk_i,
    .arst_n_i,
    .up(fwd),
    .bank_fwd);

  generate
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      mem_bank #(
        .BANK_WORDS(BANK_WORDS),
        .FIFO_DEPTH(FIFO_DEPTH)
      ) u_bank (
        .clk_i,
        .arst_n_i,
        .req(bank_fwd[b]),
        .rsp(bank_rev[b]));
    end
  endgenerate

  mem_rev_merger #(
    .NUM_BANKS(NUM_BANKS)
  ) u_merger (
    .clk_i,
    .arst_n_i,
    .bank_rev,
    .down(rev));

endmodule

// ==== hdl/mem_rev_merger.sv ====
`timescale 1ns/10ps

module mem_rev_merger
  import axi_pkg::*;
  import mem_msg_pkg::*;
  #(parameter int NUM_BANKS = 4)
  (input  logic   clk_i,
   input  logic   arst_n_i,
   mem_rev_if.dst bank_rev [NUM_BANKS],
   mem_rev_if.src down);

  localparam int          SEL_W        = $clog2(NUM_BANKS);
  localparam credit_cnt_t DOWN_CREDITS = 3'd2;  // one read and one write slot

  logic [NUM_BANKS-1:0] in_v, held_v;
  mem_msg_e             held_msg [NUM_BANKS];
  axi_data_t            held_data [NUM_BANKS];
  logic                 held_err [NUM_BANKS];
  logic [SEL_W-1:0]     rr_ptr, gnt;
  logic                 found, go;
  credit_cnt_t          down_cred;

  // ------------------------------
  // per-bank holding registers
  // ------------------------------
  generate
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_in
      assign in_v[b]            = bank_rev[b].valid;
      assign bank_rev[b].credit = go && (gnt == b);  // register empties

      always_ff @(posedge clk_i) begin
        if (bank_rev[b].valid) begin
          held_msg[b]  <= bank_rev[b].msg;
          held_data[b] <= bank_rev[b].data;
          held_err[b]  <= bank_rev[b].err;
        end
      end
    end
  endgenerate

  // round robin, search starts at the bank after the last winner
  always_comb begin
    logic [SEL_W-1:0] idx;
    gnt   = rr_ptr;
    found = 1'b0;
    for (int i = 0; i < NUM_BANKS; i++) begin
      idx = rr_ptr + SEL_W'(i);
      if (!found && held_v[idx]) begin
        gnt   = idx;
        found = 1'b1;
      end
    end
  end

  assign go         = found && (down_cred != '0);
  assign down.valid = go;
  assign down.msg   = held_msg[gnt];
  assign down.data  = held_data[gnt];
  assign down.err   = held_err[gnt];

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      held_v    <= '0;
      rr_ptr    <= '0;
      down_cred <= DOWN_CREDITS;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (in_v[b]) held_v[b] <= 1'b1;
      end
      if (go) begin
        held_v[gnt] <= 1'b0;
        rr_ptr      <= gnt + 1'b1;
      end
      down_cred <= down_cred - credit_cnt_t'(go) + credit_cnt_t'(down.credit);
    end
  end

endmodule

// ==== hdl/mem_bank.sv ====
`timescale 1ns/10ps

module mem_bank
  import axi_pkg::*;
  import mem_msg_pkg::*;
  #(parameter int BANK_WORDS = 16,
    parameter int FIFO_DEPTH = 2)
  (input  logic   clk_i,
   input  logic   arst_n_i,
   mem_fwd_if.dst req,
   mem_rev_if.src rsp);

  localparam int IDX_W = $clog2(BANK_WORDS);
  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int PL_W  = 1 + IDX_W + $bits(axi_data_t) + $bits(axi_strb_t);

  axi_data_t        mem_q [BANK_WORDS];
  logic [PL_W-1:0]  fifo_q [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr, rd_ptr;
  logic [CNT_W-1:0] count;
  credit_cnt_t      rsp_cred;  // one slot at the merger
  logic             pop;
  mem_msg_e         pop_msg;
  logic [IDX_W-1:0] pop_idx;
  axi_data_t        pop_data;
  axi_strb_t        pop_strb;
  logic             rsp_v_q;
  mem_msg_e         rsp_msg_q;
  axi_data_t        rsp_data_q;

  assign pop     = (count != '0) && (rsp_cred != '0);
  assign pop_msg = mem_msg_e'(fifo_q[rd_ptr][PL_W-1]);
  assign {pop_idx, pop_data, pop_strb} = fifo_q[rd_ptr][PL_W-2:0];

  assign req.credit = pop;  // entry leaves the FIFO
  assign rsp.valid  = rsp_v_q;
  assign rsp.msg    = rsp_msg_q;
  assign rsp.data   = rsp_data_q;
  assign rsp.err    = 1'b0;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr   <= '0;
      rd_ptr   <= '0;
      count    <= '0;
      rsp_cred <= credit_cnt_t'(1);
      rsp_v_q  <= 1'b0;
    end else begin
      if (req.valid)
        wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count    <= count + CNT_W'(req.valid) - CNT_W'(pop);
      rsp_cred <= rsp_cred - credit_cnt_t'(pop) + credit_cnt_t'(rsp.credit);
      rsp_v_q  <= pop;
    end
  end

  // ------------------------------
  // FIFO write and word store
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (req.valid) fifo_q[wr_ptr] <= {req.msg, req.addr[IDX_W-1:0], req.data, req.strb};
    if (pop) begin
      rsp_msg_q  <= pop_msg;
      rsp_data_q <= mem_q[pop_idx];  // ack of a write carries the old word
      if (pop_msg == MEM_WR) begin
        for (int i = 0; i < $bits(axi_strb_t); i++) begin
          if (pop_strb[i]) mem_q[pop_idx][8*i +: 8] <= pop_data[8*i +: 8];
        end
      end
    end
  end

  a_no_overflow: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    req.valid |-> count < FIFO_DEPTH);

endmodule

// ==== hdl/mem_fwd_router.sv ====
`timescale 1ns/10ps

module mem_fwd_router
  import axi_pkg::*;
  import mem_msg_pkg::*;
  #(parameter int NUM_BANKS  = 4,
    parameter int FIFO_DEPTH = 2)
  (input  logic   clk_i,
   input  logic   arst_n_i,
   mem_fwd_if.dst up,
   mem_fwd_if.src bank_fwd [NUM_BANKS]);

  localparam int SEL_W = $clog2(NUM_BANKS);
  localparam int PL_W  = 1 + $bits(word_addr_t) + $bits(axi_data_t) + $bits(axi_strb_t);

  logic [PL_W-1:0]  in_pl, hold_pl, skid_pl;
  logic             hold_v, skid_v;
  mem_msg_e         hold_msg;
  word_addr_t       hold_addr;
  axi_data_t        hold_data;
  axi_strb_t        hold_strb;
  logic [SEL_W-1:0] sel;
  credit_cnt_t      cred_q [NUM_BANKS];
  logic             go;

  assign in_pl     = {up.msg, up.addr, up.data, up.strb};
  assign hold_msg  = mem_msg_e'(hold_pl[PL_W-1]);
  assign {hold_addr, hold_data, hold_strb} = hold_pl[PL_W-2:0];

  assign sel       = hold_addr[SEL_W-1:0];  // low word bits pick the bank
  assign go        = hold_v && (cred_q[sel] != '0);
  assign up.credit = go;                    // message leaves the router

  // ------------------------------
  // holding register and skid
  // ------------------------------
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      hold_v <= 1'b0;
      skid_v <= 1'b0;
    end else if (!hold_v || go) begin
      hold_v <= skid_v || up.valid;
      skid_v <= skid_v && up.valid;
    end else if (up.valid) begin
      skid_v <= 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!hold_v || go) hold_pl <= skid_v ? skid_pl : in_pl;  // older entry first
    if (up.valid) skid_pl <= in_pl;
  end

  // ------------------------------
  // per-bank outputs and credits
  // ------------------------------
  generate
    for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
      assign bank_fwd[b].valid = go && (sel == b);
      assign bank_fwd[b].msg   = hold_msg;
      assign bank_fwd[b].addr  = hold_addr >> SEL_W;  // bank bits stripped
      assign bank_fwd[b].data  = hold_data;
      assign bank_fwd[b].strb  = hold_strb;

      always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i)
          cred_q[b] <= credit_cnt_t'(FIFO_DEPTH);
        else
          cred_q[b] <= cred_q[b] - credit_cnt_t'(bank_fwd[b].valid)
                       + credit_cnt_t'(bank_fwd[b].credit);
      end

      a_cred_max: assert property (@(posedge clk_i) disable iff (!arst_n_i)
        cred_q[b] <= FIFO_DEPTH);
    end
  endgenerate

endmodule

// ==== hdl/axi_subordinate.sv ====
`timescale 1ns/10ps

module axi_subordinate
  import axi_pkg::*;
  import mem_msg_pkg::*;
  #(parameter int ID_WIDTH   = 4,
    parameter int BANK_WORDS = 16,
    parameter int NUM_BANKS  = 4)
  (input  logic                clk_i,
   input  logic                arst_n_i,
   input  logic [ID_WIDTH-1:0] awid_i,
   input  axi_addr_t           awaddr_i,
   input  axi_len_t            awlen_i,
   input  logic                awvalid_i,
   output logic                awready_o,
   input  axi_data_t           wdata_i,
   input  axi_strb_t           wstrb_i,
   input  logic                wlast_i,
   input  logic                wvalid_i,
   output logic                wready_o,
   output logic [ID_WIDTH-1:0] bid_o,
   output axi_resp_t           bresp_o,
   output logic                bvalid_o,
   input  logic                bready_i,
   input  logic [ID_WIDTH-1:0] arid_i,
   input  axi_addr_t           araddr_i,
   input  axi_len_t            arlen_i,
   input  logic                arvalid_i,
   output logic                arready_o,
   output logic [ID_WIDTH-1:0] rid_o,
   output axi_data_t           rdata_o,
   output axi_resp_t           rresp_o,
   output logic                rlast_o,
   output logic                rvalid_o,
   input  logic                rready_i,
   mem_fwd_if.src              fwd,
   mem_rev_if.dst              rev);

  localparam int          MEM_WORDS   = NUM_BANKS * BANK_WORDS;
  localparam credit_cnt_t FWD_CREDITS = 3'd2;

  typedef enum logic [1:0] {IDLE, ISSUE, WAIT, RESP} slot_state_e;

  slot_state_e         wr_state, rd_state;
  logic                aw_got, w_got;   // halves of a write seen so far
  logic [ID_WIDTH-1:0] awid_q, arid_q;
  axi_addr_t           awaddr_q, araddr_q;
  axi_len_t            awlen_q;
  logic                wlast_q;
  axi_data_t           wdata_q, rdata_q;
  axi_strb_t           wstrb_q;
  axi_resp_t           bresp_q, rresp_q;
  credit_cnt_t         fwd_cred;
  logic                wr_turn;         // write wins the next tie
  logic                aw_hs, w_hs, ar_hs, b_hs, r_hs;
  axi_addr_t           wr_addr_v;
  axi_len_t            wr_len_v;
  logic                wr_last_v;
  axi_resp_t           wr_chk, rd_chk;
  logic                send_wr, send_rd, rev_wr, rev_rd;

  assign awready_o = (wr_state == IDLE) && !aw_got;
  assign wready_o  = (wr_state == IDLE) && !w_got;
  assign arready_o = (rd_state == IDLE);
  assign aw_hs     = awvalid_i && awready_o;
  assign w_hs      = wvalid_i && wready_o;
  assign ar_hs     = arvalid_i && arready_o;
  assign b_hs      = bvalid_o && bready_i;
  assign r_hs      = rvalid_o && rready_i;

  // ------------------------------
  // request checks
  // ------------------------------
  assign wr_addr_v = aw_hs ? awaddr_i : awaddr_q;  // beat on the bus wins
  assign wr_len_v  = aw_hs ? awlen_i : awlen_q;
  assign wr_last_v = w_hs ? wlast_i : wlast_q;

  always_comb begin
    if (wr_len_v != '0 || !wr_last_v)
      wr_chk = RESP_SLVERR;
    else if (wr_addr_v[31:3] >= MEM_WORDS)
      wr_chk = RESP_DECERR;
    else
      wr_chk = RESP_OKAY;
    if (arlen_i != '0)
      rd_chk = RESP_SLVERR;
    else if (araddr_i[31:3] >= MEM_WORDS)
      rd_chk = RESP_DECERR;
    else
      rd_chk = RESP_OKAY;
  end

  // ------------------------------
  // issue toward the router
  // ------------------------------
  assign send_wr = (fwd_cred != '0) && (wr_state == ISSUE)
                   && (wr_turn || rd_state != ISSUE);
  assign send_rd = (fwd_cred != '0) && (rd_state == ISSUE) && !send_wr;

  assign fwd.valid = send_wr || send_rd;
  assign fwd.msg   = send_wr ? MEM_WR : MEM_RD;
  assign fwd.addr  = send_wr ? awaddr_q[31:3] : araddr_q[31:3];
  assign fwd.data  = wdata_q;
  assign fwd.strb  = wstrb_q;

  assign rev_wr = rev.valid && (rev.msg == MEM_WR);
  assign rev_rd = rev.valid && (rev.msg == MEM_RD);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_state <= IDLE;
      aw_got   <= 1'b0;
      w_got    <= 1'b0;
      bresp_q  <= RESP_OKAY;
    end else begin
      case (wr_state)
        IDLE: begin
          if ((aw_got || aw_hs) && (w_got || w_hs)) begin
            aw_got   <= 1'b0;
            w_got    <= 1'b0;
            bresp_q  <= wr_chk;
            wr_state <= (wr_chk == RESP_OKAY) ? ISSUE : RESP;
          end else begin
            aw_got <= aw_got || aw_hs;
            w_got  <= w_got || w_hs;
          end
        end
        ISSUE: if (send_wr) wr_state <= WAIT;
        WAIT: begin
          if (rev_wr) begin
            bresp_q  <= rev.err ? RESP_SLVERR : RESP_OKAY;
            wr_state <= RESP;
          end
        end
        default: if (b_hs) wr_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rd_state <= IDLE;
      rresp_q  <= RESP_OKAY;
    end else begin
      case (rd_state)
        IDLE: begin
          if (ar_hs) begin
            rresp_q  <= rd_chk;
            rd_state <= (rd_chk == RESP_OKAY) ? ISSUE : RESP;
          end
        end
        ISSUE: if (send_rd) rd_state <= WAIT;
        WAIT: begin
          if (rev_rd) begin
            rresp_q  <= rev.err ? RESP_SLVERR : RESP_OKAY;
            rd_state <= RESP;
          end
        end
        default: if (r_hs) rd_state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      fwd_cred   <= FWD_CREDITS;
      wr_turn    <= 1'b1;
      rev.credit <= 1'b0;
    end else begin
      fwd_cred   <= fwd_cred - credit_cnt_t'(fwd.valid) + credit_cnt_t'(fwd.credit);
      if (fwd.valid) wr_turn <= send_rd;  // alternate on ties
      rev.credit <= rev.valid;            // message is latched into its slot
    end
  end

  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      awid_q   <= awid_i;
      awaddr_q <= awaddr_i;
      awlen_q  <= awlen_i;
    end
    if (w_hs) begin
      wdata_q <= wdata_i;
      wstrb_q <= wstrb_i;
      wlast_q <= wlast_i;
    end
    if (ar_hs) begin
      arid_q   <= arid_i;
      araddr_q <= araddr_i;
      rdata_q  <= '0;  // error reads return zero
    end else if (rev_rd) begin
      rdata_q <= rev.data;
    end
  end

  assign bvalid_o = (wr_state == RESP);
  assign bid_o    = awid_q;
  assign bresp_o  = bresp_q;
  assign rvalid_o = (rd_state == RESP);
  assign rid_o    = arid_q;
  assign rdata_o  = rdata_q;
  assign rresp_o  = rresp_q;
  assign rlast_o  = rvalid_o;  // single beat only

  // ------------------------------
  // checks
  // ------------------------------
  a_b_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    bvalid_o && !bready_i |=> bvalid_o && $stable({bid_o, bresp_o}));

  a_r_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    rvalid_o && !rready_i |=> rvalid_o && $stable({rid_o, rdata_o, rresp_o}));

  // a send at zero or a stray credit pushes the count past its start value
  a_fwd_credit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    fwd_cred <= FWD_CREDITS);

endmodule

// ==== hdl/mem_rev_if.sv ====
`timescale 1ns/10ps

interface mem_rev_if
  import axi_pkg::*;
  import mem_msg_pkg::*;
  ();

  logic      valid;   // one cycle per message
  mem_msg_e  msg;     // tells B from R at the front end
  axi_data_t data;
  logic      err;
  logic      credit;  // flows back, one pulse per freed slot

  modport src (output valid, msg, data, err, input credit);
  modport dst (input valid, msg, data, err, output credit);

endinterface

// ==== hdl/mem_fwd_if.sv ====
`timescale 1ns/10ps

interface mem_fwd_if
  import axi_pkg::*;
  import mem_msg_pkg::*;
  ();

  logic       valid;   // one cycle per message
  mem_msg_e   msg;
  word_addr_t addr;
  axi_data_t  data;
  axi_strb_t  strb;
  logic       credit;  // flows back, one pulse per freed slot

  modport src (output valid, msg, addr, data, strb, input credit);
  modport dst (input valid, msg, addr, data, strb, output credit);

endinterface

// ==== hdl/mem_msg_pkg.sv ====
package mem_msg_pkg;

  // ------------------------------
  // fabric message fields
  // ------------------------------
  typedef enum logic {
    MEM_RD = 1'b0,
    MEM_WR = 1'b1
  } mem_msg_e;

  typedef logic [28:0] word_addr_t;  // byte address without the 3 lane bits

  // ------------------------------
  // flow control
  // ------------------------------
  typedef logic [2:0] credit_cnt_t;  // enough for any link in the fabric

endpackage

// ==== hdl/axi_pkg.sv ====
package axi_pkg;

  // ------------------------------
  // channel field widths
  // ------------------------------
  typedef logic [63:0] axi_data_t;  // one full beat
  typedef logic [7:0]  axi_strb_t;  // one bit per byte lane
  typedef logic [31:0] axi_addr_t;  // byte address
  typedef logic [7:0]  axi_len_t;   // beats minus one
  typedef logic [1:0]  axi_resp_t;

  // ------------------------------
  // response codes
  // ------------------------------
  localparam axi_resp_t RESP_OKAY   = 2'b00;
  localparam axi_resp_t RESP_SLVERR = 2'b10;  // bad length or missing wlast
  localparam axi_resp_t RESP_DECERR = 2'b11;  // outside the memory

endpackage
